// ==== Makefile ====
TOP := tb_frontend

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall -f tb.f --top-module frontend_top

clean:
	rm -rf obj_dir sim.log

// ==== design/decode_lane.sv ====
`timescale 1ns/10ps

module decode_lane import fe_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_flush,
    input  logic              i_load,
    input  logic              i_can_read,
    input  logic [INSN_W-1:0] i_insn,
    output logic              o_rd_en,
    output logic              o_valid,
    output opcode_e           o_op,
    output logic [REG_W-1:0]  o_rd,
    output logic [REG_W-1:0]  o_rs1,
    output logic [IMM_W-1:0]  o_imm
);

    function automatic opcode_e decode_op(input logic [OP_W-1:0] code);
        case (code)
            4'd0:    return OP_NOP;
            4'd1:    return OP_ADD;
            4'd2:    return OP_ADDI;
            4'd3:    return OP_LOAD;
            4'd4:    return OP_STORE;
            4'd5:    return OP_JUMP;
            default: return OP_ILLEGAL;
        endcase
    endfunction

    // Pops the queue port only on a group load.
    assign o_rd_en = i_load && i_can_read;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (i_load) begin
            o_valid <= i_can_read;    // Empty port leaves the lane empty.
        end
    end

    always_ff @(posedge clk) begin
        if (o_rd_en) begin
            o_op  <= decode_op(i_insn[OP_LSB +: OP_W]);
            o_rd  <= i_insn[RD_LSB +: REG_W];
            o_rs1 <= i_insn[RS1_LSB +: REG_W];
            o_imm <= i_insn[IMM_LSB +: IMM_W];
        end
    end

endmodule

// ==== design/dispatch_unit.sv ====
`timescale 1ns/10ps

module dispatch_unit import fe_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [LANES-1:0]    i_lane_valid,
    input  opcode_e             i_lane_op [LANES],
    input  logic [REG_W-1:0]    i_lane_rd [LANES],
    input  logic [REG_W-1:0]    i_lane_rs1 [LANES],
    input  logic [IMM_W-1:0]    i_lane_imm [LANES],
    input  logic                i_issue_ready,
    output logic                o_load,
    output logic [LANES-1:0]    o_issue_valid,
    output opcode_e             o_issue_op [LANES],
    output logic [REG_W-1:0]    o_issue_rd [LANES],
    output logic [REG_W-1:0]    o_issue_rs1 [LANES],
    output logic [IMM_W-1:0]    o_issue_imm [LANES],
    output logic                o_redirect,
    output logic [WB_ADR_W-1:0] o_redirect_adr
);

    logic [LANES-1:0] is_jump;
    logic [LANES-1:0] slot_valid;
    logic             jump_taken;
    logic [IMM_W-1:0] jump_imm;

    for (genvar i = 0; i < LANES; i++) begin : gen_slot
        assign is_jump[i]     = (i_lane_op[i] == OP_JUMP);
        assign o_issue_op[i]  = i_lane_op[i];
        assign o_issue_rd[i]  = i_lane_rd[i];
        assign o_issue_rs1[i] = i_lane_rs1[i];
        assign o_issue_imm[i] = i_lane_imm[i];
    end

    // ############################################################
    // Slot forming and jump detection.
    // ############################################################
    always_comb begin
        slot_valid = i_lane_valid;
        for (int i = 1; i < LANES; i++) begin
            if (!slot_valid[i-1] || is_jump[i-1]) begin
                slot_valid[i] = 1'b0;   // Younger than a jump.
            end
        end
        jump_taken = 1'b0;
        jump_imm   = '0;
        for (int i = 0; i < LANES; i++) begin
            if (slot_valid[i] && !o_redirect && is_jump[i] && !jump_taken) begin
                jump_taken = 1'b1;
                jump_imm   = i_lane_imm[i];
            end
        end
    end

    // Lanes hold stale work in the redirect cycle.
    assign o_issue_valid = slot_valid & {LANES{!o_redirect}};

    // Refill when empty or when everything held leaves now.
    assign o_load = !(|i_lane_valid) || i_issue_ready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_redirect <= 1'b0;
        end else begin
            o_redirect <= jump_taken && i_issue_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (jump_taken && i_issue_ready) begin
            o_redirect_adr <= WB_ADR_W'(jump_imm);   // Target word index.
        end
    end

endmodule

// ==== design/fe_pkg.sv ====
package fe_pkg;

    // ############################################################
    // Instruction format.
    // ############################################################
    localparam int INSN_W  = 32;
    localparam int OP_W    = 4;
    localparam int REG_W   = 4;
    localparam int IMM_W   = 20;

    // Bit positions of the fields inside an instruction.
    localparam int OP_LSB  = 28;
    localparam int RD_LSB  = 24;
    localparam int RS1_LSB = 20;
    localparam int IMM_LSB = 0;

    // ############################################################
    // Instruction bus.
    // ############################################################
    localparam int WB_DAT_W = 64;
    localparam int WB_ADR_W = 20;   // Word address of one fetch.

    // Instructions per fetch word and the number of queue ports and decode lanes.
    localparam int LANES = WB_DAT_W / INSN_W;

    // Decoded operation. Codes 6 to 15 all decode to OP_ILLEGAL.
    typedef enum logic [OP_W-1:0] {
        OP_NOP     = 4'd0,
        OP_ADD     = 4'd1,
        OP_ADDI    = 4'd2,
        OP_LOAD    = 4'd3,
        OP_STORE   = 4'd4,
        OP_JUMP    = 4'd5,
        OP_ILLEGAL = 4'd15
    } opcode_e;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import fe_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    input  logic                i_wb_ack,
    input  logic [LANES-1:0]    i_can_write,
    input  logic                i_redirect,
    input  logic [WB_ADR_W-1:0] i_redirect_adr,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output logic [WB_ADR_W-1:0] o_wb_adr,
    output logic [LANES-1:0]    o_wr_en,
    output logic [INSN_W-1:0]   o_wr_data [LANES]
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DROP
    } state_e;

    state_e              state;
    logic [WB_ADR_W-1:0] adr_q;     // Address of the current or next request.
    logic [WB_ADR_W-1:0] target_q;  // Jump target held while a stale reply is pending.
    logic                push;

    // A reply is only kept when no redirect lands in the same cycle.
    assign push = (state == REQ) && i_wb_ack && !i_redirect;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            adr_q    <= '0;
            target_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_redirect) begin
                        adr_q <= i_redirect_adr;
                    end else if (&i_can_write) begin
                        state <= REQ;         // Room for a whole word.
                    end
                end
                REQ: begin
                    if (i_redirect) begin
                        if (i_wb_ack) begin
                            adr_q <= i_redirect_adr;
                            state <= IDLE;
                        end else begin
                            target_q <= i_redirect_adr;
                            state    <= DROP;
                        end
                    end else if (i_wb_ack) begin
                        adr_q <= adr_q + 1'b1;
                        state <= IDLE;        // Stb drops for one cycle.
                    end
                end
                DROP: begin
                    if (i_wb_ack) begin
                        adr_q <= i_redirect ? i_redirect_adr : target_q;
                        state <= IDLE;
                    end else if (i_redirect) begin
                        target_q <= i_redirect_adr;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Bus stays held through DROP until the pending ack.
    assign o_wb_cyc = (state != IDLE);
    assign o_wb_stb = (state != IDLE);
    assign o_wb_adr = adr_q;
    assign o_wr_en  = {LANES{push}};

    // Low half is the older instruction.
    for (genvar i = 0; i < LANES; i++) begin : gen_half
        assign o_wr_data[i] = i_wb_dat[i*INSN_W +: INSN_W];
    end

endmodule

// ==== design/frontend_top.sv ====
`timescale 1ns/10ps

module frontend_top import fe_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    input  logic                i_wb_ack,
    input  logic                i_issue_ready,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output logic [WB_ADR_W-1:0] o_wb_adr,
    output logic [LANES-1:0]    o_issue_valid,
    output opcode_e             o_issue_op [LANES],
    output logic [REG_W-1:0]    o_issue_rd [LANES],
    output logic [REG_W-1:0]    o_issue_rs1 [LANES],
    output logic [IMM_W-1:0]    o_issue_imm [LANES]
);

    logic [LANES-1:0]    can_write;
    logic [LANES-1:0]    wr_en;
    logic [INSN_W-1:0]   wr_data [LANES];
    logic [LANES-1:0]    can_read;
    logic [LANES-1:0]    rd_en;
    logic [INSN_W-1:0]   rd_data [LANES];
    logic                load;
    logic [LANES-1:0]    lane_valid;
    opcode_e             lane_op [LANES];
    logic [REG_W-1:0]    lane_rd [LANES];
    logic [REG_W-1:0]    lane_rs1 [LANES];
    logic [IMM_W-1:0]    lane_imm [LANES];
    logic                redirect;
    logic [WB_ADR_W-1:0] redirect_adr;

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .i_can_write   (can_write),
        .i_redirect    (redirect),
        .i_redirect_adr(redirect_adr),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .o_wr_en       (wr_en),
        .o_wr_data     (wr_data)
    );

    inst_queue #(
        .DEPTH(DEPTH)
    ) inst_queue_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (redirect),
        .i_wr_en    (wr_en),
        .i_wr_data  (wr_data),
        .i_rd_en    (rd_en),
        .o_can_write(can_write),
        .o_can_read (can_read),
        .o_rd_data  (rd_data)
    );

    // One lane per queue read port, loaded as a group.
    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        decode_lane decode_lane_i (
            .clk       (clk),
            .i_rst_n   (i_rst_n),
            .i_flush   (redirect),
            .i_load    (load),
            .i_can_read(can_read[i]),
            .i_insn    (rd_data[i]),
            .o_rd_en   (rd_en[i]),
            .o_valid   (lane_valid[i]),
            .o_op      (lane_op[i]),
            .o_rd      (lane_rd[i]),
            .o_rs1     (lane_rs1[i]),
            .o_imm     (lane_imm[i])
        );
    end

    dispatch_unit dispatch_unit_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_lane_valid  (lane_valid),
        .i_lane_op     (lane_op),
        .i_lane_rd     (lane_rd),
        .i_lane_rs1    (lane_rs1),
        .i_lane_imm    (lane_imm),
        .i_issue_ready (i_issue_ready),
        .o_load        (load),
        .o_issue_valid (o_issue_valid),
        .o_issue_op    (o_issue_op),
        .o_issue_rd    (o_issue_rd),
        .o_issue_rs1   (o_issue_rs1),
        .o_issue_imm   (o_issue_imm),
        .o_redirect    (redirect),
        .o_redirect_adr(redirect_adr)
    );

endmodule

// ==== design/inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue import fe_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_flush,
    input  logic [LANES-1:0]  i_wr_en,
    input  logic [INSN_W-1:0] i_wr_data [LANES],
    input  logic [LANES-1:0]  i_rd_en,
    output logic [LANES-1:0]  o_can_write,
    output logic [LANES-1:0]  o_can_read,
    output logic [INSN_W-1:0] o_rd_data [LANES]
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int SUM_W = CNT_W + 1;

    logic [INSN_W-1:0] buffer [DEPTH];
    logic [PTR_W-1:0]  wptr [LANES];
    logic [PTR_W-1:0]  rptr [LANES];
    logic [CNT_W-1:0]  count;
    logic [LANES-1:0]  wr_ok;
    logic [LANES-1:0]  rd_ok;
    logic [CNT_W-1:0]  wr_num;
    logic [CNT_W-1:0]  rd_num;

    // Enables are a prefix, so the number of set bits is the advance.
    function automatic logic [CNT_W-1:0] ones(input logic [LANES-1:0] v);
        logic [CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < LANES; i++) begin
            n = n + CNT_W'(v[i]);
        end
        return n;
    endfunction

    function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] p,
                                                  input logic [CNT_W-1:0] n);
        logic [SUM_W-1:0] sum;
        sum = SUM_W'(p) + SUM_W'(n);
        if (sum >= SUM_W'(DEPTH)) begin
            sum = sum - SUM_W'(DEPTH);
        end
        return PTR_W'(sum);
    endfunction

    assign wr_ok  = i_wr_en & o_can_write;
    assign rd_ok  = i_rd_en & o_can_read;
    assign wr_num = ones(wr_ok);
    assign rd_num = ones(rd_ok);

    // ############################################################
    // Pointers and occupancy.
    // ############################################################
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
            for (int i = 0; i < LANES; i++) begin
                wptr[i] <= PTR_W'(i);
                rptr[i] <= PTR_W'(i);
            end
        end else if (i_flush) begin
            count <= '0;
            for (int i = 0; i < LANES; i++) begin
                wptr[i] <= PTR_W'(i);   // Back to the port offsets.
                rptr[i] <= PTR_W'(i);
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                wptr[i] <= wrap_add(wptr[i], wr_num);
                rptr[i] <= wrap_add(rptr[i], rd_num);
            end
            count <= count + wr_num - rd_num;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_ok[i] && !i_flush) begin
                buffer[wptr[i]] <= i_wr_data[i];
            end
        end
    end

    // Port i sees the head plus i.
    for (genvar i = 0; i < LANES; i++) begin : gen_port
        assign o_can_write[i] = (CNT_W'(DEPTH) - count) > CNT_W'(i);
        assign o_can_read[i]  = count > CNT_W'(i);
        assign o_rd_data[i]   = buffer[rptr[i]];
    end

endmodule

// ==== tb.f ====
design/fe_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/decode_lane.sv
design/dispatch_unit.sv
design/frontend_top.sv
tests/tb_frontend.sv

// ==== tests/tb_frontend.sv ====
`timescale 1ns/10ps

module tb_frontend import fe_pkg::*; ();

    localparam int RESET_CYCLES   = 3;
    localparam int PROG_WORDS     = 16;
    localparam int CYCLES_PER_EXP = 40;
    localparam int STALL_START    = 12;   // Long stall that fills the queue.
    localparam int STALL_END      = 40;

    logic                clk = 1'b0;
    logic                i_rst_n;
    logic [WB_DAT_W-1:0] i_wb_dat;
    logic                i_wb_ack;
    logic                i_issue_ready;
    logic                o_wb_cyc;
    logic                o_wb_stb;
    logic [WB_ADR_W-1:0] o_wb_adr;
    logic [LANES-1:0]    o_issue_valid;
    opcode_e             o_issue_op [LANES];
    logic [REG_W-1:0]    o_issue_rd [LANES];
    logic [REG_W-1:0]    o_issue_rs1 [LANES];
    logic [IMM_W-1:0]    o_issue_imm [LANES];

    logic [WB_DAT_W-1:0] program_mem [PROG_WORDS];
    opcode_e             exp_op [$];
    logic [REG_W-1:0]    exp_rd [$];
    logic [REG_W-1:0]    exp_rs1 [$];
    logic [IMM_W-1:0]    exp_imm [$];
    int                  n_exp;
    int                  exp_idx;
    int                  error_count;
    int                  timeout_count;
    int                  cycle_count;
    int                  cycle_limit;
    logic [15:0]         lfsr_q;
    logic                bus_busy;
    logic [1:0]          wait_left;
    logic                seen_ack;

    // State seen at the previous sample point.
    logic [LANES-1:0]    prev_valid;
    logic                prev_ready;
    logic                prev_stb;
    logic                prev_ack;
    logic [WB_ADR_W-1:0] prev_adr;
    opcode_e             prev_op [LANES];
    logic [REG_W-1:0]    prev_rd [LANES];
    logic [REG_W-1:0]    prev_rs1 [LANES];
    logic [IMM_W-1:0]    prev_imm [LANES];

    frontend_top #(
        .DEPTH(8)
    ) frontend_top_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_wb_dat     (i_wb_dat),
        .i_wb_ack     (i_wb_ack),
        .i_issue_ready(i_issue_ready),
        .o_wb_cyc     (o_wb_cyc),
        .o_wb_stb     (o_wb_stb),
        .o_wb_adr     (o_wb_adr),
        .o_issue_valid(o_issue_valid),
        .o_issue_op   (o_issue_op),
        .o_issue_rd   (o_issue_rd),
        .o_issue_rs1  (o_issue_rs1),
        .o_issue_imm  (o_issue_imm)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // ############################################################
    // Helpers.
    // ############################################################
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1.
    endfunction

    task automatic take_bits(input int n, output logic [1:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            bits   = {bits[0], lfsr_q[0]};
        end
    endtask

    function automatic logic [INSN_W-1:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] rs1, input logic [19:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic opcode_e expected_op(input logic [3:0] code);
        if (code > 4'd5) begin
            return OP_ILLEGAL;
        end
        return opcode_e'(code);
    endfunction

    // Unused addresses return an ADD whose imm is the whole word address.
    function automatic logic [WB_DAT_W-1:0] read_word(input logic [WB_ADR_W-1:0] adr);
        if (adr < WB_ADR_W'(PROG_WORDS)) begin
            return program_mem[adr[3:0]];
        end
        return {2{4'd1, 8'h00, adr}};
    endfunction

    task automatic put_word(input int idx, input logic [INSN_W-1:0] lo,
                            input logic [INSN_W-1:0] hi);
        program_mem[idx] = {hi, lo};   // Low half is the older slot.
    endtask

    task automatic load_program();
        put_word(0,  encode(4'd1, 4'd1, 4'd2, 20'h00011), encode(4'd2, 4'd3, 4'd4, 20'h12345));
        put_word(1,  encode(4'd3, 4'd5, 4'd6, 20'h00100), encode(4'd4, 4'd7, 4'd8, 20'hfffff));
        put_word(2,  encode(4'd0, 4'd0, 4'd0, 20'h00000), encode(4'd6, 4'd9, 4'ha, 20'h0abcd));
        put_word(3,  encode(4'd9, 4'hb, 4'hc, 20'h55555), encode(4'hf, 4'hf, 4'he, 20'haaaaa));
        put_word(4,  encode(4'd1, 4'd2, 4'd3, 20'h00000), encode(4'd5, 4'd0, 4'd0, 20'd7));
        put_word(5,  encode(4'd4, 4'd1, 4'd1, 20'h0dead), encode(4'd1, 4'd1, 4'd1, 20'h0beef));
        put_word(6,  encode(4'd2, 4'd4, 4'd4, 20'h00006), encode(4'd2, 4'd4, 4'd4, 20'h00066));
        put_word(7,  encode(4'd5, 4'd0, 4'd0, 20'd10),    encode(4'd2, 4'hd, 4'hd, 20'h0bad0));
        put_word(8,  encode(4'd3, 4'd2, 4'd2, 20'h00008), encode(4'd3, 4'd2, 4'd2, 20'h00088));
        put_word(9,  encode(4'd4, 4'd3, 4'd3, 20'h00009), encode(4'd4, 4'd3, 4'd3, 20'h00099));
        put_word(10, encode(4'hc, 4'd6, 4'd7, 20'h0c0de), encode(4'd3, 4'd8, 4'd9, 20'h00040));
        put_word(11, encode(4'd2, 4'd1, 4'd0, 20'h7ffff), encode(4'd1, 4'd2, 4'd1, 20'h00001));
        put_word(12, encode(4'd3, 4'd3, 4'd2, 20'h00010), encode(4'd4, 4'd3, 4'd4, 20'h00020));
        put_word(13, encode(4'd0, 4'd0, 4'd0, 20'h00000), encode(4'd2, 4'hf, 4'hf, 20'hfffff));
        put_word(14, encode(4'd5, 4'd0, 4'd0, 20'd14),    encode(4'd1, 4'd5, 4'd5, 20'h00014));
        put_word(15, encode(4'd1, 4'd6, 4'd6, 20'h0000f), encode(4'd1, 4'd6, 4'd6, 20'h000ff));
    endtask

    // Walks the program in issue order. A self-loop jump ends it.
    task automatic build_expected();
        logic [WB_ADR_W-1:0] pc;
        logic [INSN_W-1:0]   insn;
        int                  slot;
        logic                stop;
        pc   = '0;
        slot = 0;
        stop = 1'b0;
        while (!stop) begin
            insn = program_mem[pc[3:0]][slot*INSN_W +: INSN_W];
            exp_op.push_back(expected_op(insn[31:28]));
            exp_rd.push_back(insn[27:24]);
            exp_rs1.push_back(insn[23:20]);
            exp_imm.push_back(insn[19:0]);
            if (insn[31:28] == 4'd5) begin
                stop = (insn[19:0] == pc);
                pc   = insn[19:0];       // Younger slot of the word is dropped.
                slot = 0;
            end else if (slot == LANES - 1) begin
                pc   = pc + 1'b1;
                slot = 0;
            end else begin
                slot = slot + 1;
            end
        end
    endtask

    // ############################################################
    // Checks.
    // ############################################################
    task automatic check_op(input opcode_e got, input opcode_e exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_field(input logic [IMM_W-1:0] got, input logic [IMM_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic [LANES-1:0] got, input logic [LANES-1:0] exp,
                               input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ############################################################
    // Memory model and issue back-pressure.
    // ############################################################
    initial begin : drive_inputs
        logic [1:0] bits;
        i_wb_ack      = 1'b0;
        i_wb_dat      = '0;
        i_issue_ready = 1'b0;
        bus_busy      = 1'b0;
        wait_left     = '0;
        cycle_count   = 0;
        lfsr_q        = 16'd5583;
        forever begin
            @(posedge clk);
            #2;
            cycle_count++;
            take_bits(2, bits);
            i_issue_ready = (bits != 2'b00) &&
                            !(cycle_count >= STALL_START && cycle_count < STALL_END);
            if (i_wb_ack) begin
                i_wb_ack = 1'b0;
                bus_busy = 1'b0;
            end else if (o_wb_stb) begin
                if (!bus_busy) begin
                    bus_busy = 1'b1;
                    take_bits(2, bits);
                    wait_left = bits;            // 0 to 3 wait states.
                end
                if (wait_left == 2'd0) begin
                    i_wb_ack = 1'b1;
                    i_wb_dat = read_word(o_wb_adr);
                end else begin
                    wait_left = wait_left - 1'b1;
                end
            end
        end
    end

    // ############################################################
    // Monitor sampled mid-cycle.
    // ############################################################
    always @(negedge clk) begin : monitor
        if (!i_rst_n) begin
            check_valid(o_issue_valid, '0, "issue valid during reset");
            check_field(IMM_W'(o_wb_cyc), '0, "cyc during reset");
            check_field(IMM_W'(o_wb_stb), '0, "stb during reset");
            prev_valid = '0;
            prev_ready = 1'b0;
            prev_stb   = 1'b0;
            prev_ack   = 1'b0;
        end else begin
            if (!seen_ack) begin
                check_valid(o_issue_valid, '0, "issue valid before first ack");
                if (o_wb_stb) begin
                    check_field(o_wb_adr, '0, "first fetch address");
                end
            end
            if (i_wb_ack) begin
                seen_ack = 1'b1;
            end
            if (o_wb_stb) begin
                check_field(IMM_W'(o_wb_cyc), IMM_W'(1'b1), "cyc during stb");
            end
            if (prev_stb && !prev_ack) begin
                check_field(IMM_W'(o_wb_stb), IMM_W'(1'b1), "stb held until ack");
                check_field(o_wb_adr, prev_adr, "address held until ack");
            end
            if (prev_stb && prev_ack) begin
                check_field(IMM_W'(o_wb_stb), '0, "stb after ack");
            end
            if (o_issue_valid[1] && !o_issue_valid[0]) begin
                error_count++;
                $display("Error at %0t: issue valid %b is not a prefix", $time, o_issue_valid);
            end
            if (prev_valid != '0 && !prev_ready) begin
                check_valid(o_issue_valid, prev_valid, "issue valid under stall");
                for (int k = 0; k < LANES; k++) begin
                    if (prev_valid[k]) begin
                        check_op(o_issue_op[k], prev_op[k], $sformatf("held slot %0d op", k));
                        check_field(IMM_W'(o_issue_rd[k]), IMM_W'(prev_rd[k]), "held rd");
                        check_field(IMM_W'(o_issue_rs1[k]), IMM_W'(prev_rs1[k]), "held rs1");
                        check_field(o_issue_imm[k], prev_imm[k], "held imm");
                    end
                end
            end
            if (i_issue_ready) begin
                for (int k = 0; k < LANES; k++) begin
                    if (o_issue_valid[k] && exp_idx < n_exp) begin
                        check_op(o_issue_op[k], exp_op[exp_idx], $sformatf("entry %0d op", exp_idx));
                        check_field(IMM_W'(o_issue_rd[k]), IMM_W'(exp_rd[exp_idx]),
                                    $sformatf("entry %0d rd", exp_idx));
                        check_field(IMM_W'(o_issue_rs1[k]), IMM_W'(exp_rs1[exp_idx]),
                                    $sformatf("entry %0d rs1", exp_idx));
                        check_field(o_issue_imm[k], exp_imm[exp_idx],
                                    $sformatf("entry %0d imm", exp_idx));
                        exp_idx++;
                    end else if (o_issue_valid[k]) begin
                        error_count++;
                        $display("Error at %0t: slot %0d issued past the program end", $time, k);
                    end
                end
            end
            prev_valid = o_issue_valid;
            prev_ready = i_issue_ready;
            prev_stb   = o_wb_stb;
            prev_ack   = i_wb_ack;
            prev_adr   = o_wb_adr;
            prev_op    = o_issue_op;
            prev_rd    = o_issue_rd;
            prev_rs1   = o_issue_rs1;
            prev_imm   = o_issue_imm;
        end
    end

    initial begin : run_test
        i_rst_n       = 1'b0;
        exp_idx       = 0;
        error_count   = 0;
        timeout_count = 0;
        seen_ack      = 1'b0;
        load_program();
        build_expected();
        n_exp       = exp_op.size();
        cycle_limit = RESET_CYCLES + CYCLES_PER_EXP * n_exp;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        i_rst_n = 1'b1;
        while (exp_idx < n_exp && cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        if (exp_idx < n_exp) begin
            timeout_count++;
            $display("Timeout: only %0d of %0d instructions issued within %0d cycles",
                     exp_idx, n_exp, cycle_limit);
        end
        $display("Summary: %0d value errors, %0d timeouts, %0d of %0d entries issued",
                 error_count, timeout_count, exp_idx, n_exp);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
